// ==== verilog/pixels_consts.svh ====
`ifndef PIXELS_CONSTS_SVH
`define PIXELS_CONSTS_SVH

// bits per pixel word
`define WORD_WIDTH 8

// words in one output window
`define ROWS 4

// tallest kernel the shift stage supports
`define KH_MAX 4

// words held by each lane, enough to slide a full kernel across one window
`define IM_SHIFT_REGS 7

// kernel shift count, wide enough for KH_MAX-1
`define BITS_SH 2

// parallel lanes in the shift stage
`define LANES 3

// sideband carried unchanged from input to every output beat
`define TUSER_WIDTH_PIXELS 4

`endif

// ==== verilog/pixels_pkg.sv ====
`include "pixels_consts.svh"

package pixels_pkg;

  // one input beat for the whole stage, one column window per lane
  typedef struct packed {
    logic [`LANES-1:0][`IM_SHIFT_REGS-1:0][`WORD_WIDTH-1:0] data;
    logic [`BITS_SH-1:0]                                    shift;
    logic [`TUSER_WIDTH_PIXELS-1:0]                         user;
  } pixels_in_t;

  // what a single lane receives from the dispatcher
  typedef struct packed {
    logic [`IM_SHIFT_REGS-1:0][`WORD_WIDTH-1:0] data;
    logic [`BITS_SH-1:0]                        shift;
    logic [`TUSER_WIDTH_PIXELS-1:0]             user;
  } lane_in_t;

  // one sliding window out of a lane
  typedef struct packed {
    logic [`ROWS-1:0][`WORD_WIDTH-1:0] data;
    logic [`TUSER_WIDTH_PIXELS-1:0]    user;
    logic                              last;
  } lane_out_t;

  // merged output beat, last marks the final window of an input beat
  typedef struct packed {
    logic [`LANES-1:0][`ROWS-1:0][`WORD_WIDTH-1:0] data;
    logic [`TUSER_WIDTH_PIXELS-1:0]                user;
    logic                                          last;
  } pixels_out_t;

endpackage

// ==== verilog/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             aclk,
  input  logic             arst_n,
  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,
  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data
);

  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             out_free;

  // the spare entry decides ready, so m_ready never reaches s_ready
  assign s_ready  = !skid_valid;
  assign out_free = m_ready || !m_valid;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_free) begin
        m_valid    <= skid_valid || s_valid;
        skid_valid <= 1'b0;
      end else if (s_valid && s_ready) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (out_free) begin
      if (skid_valid) begin
        m_data <= skid_data;
      end else begin
        m_data <= s_data;
      end
    end else if (s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

  // a stalled output beat must not change under the receiver
  assert property (@(posedge aclk) disable iff (!arst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

endmodule

// ==== verilog/pixels_dispatch.sv ====
`timescale 1ns/1ps
`include "pixels_consts.svh"

module pixels_dispatch import pixels_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  input  logic              s_valid,
  output logic              s_ready,
  input  pixels_in_t        s_data,
  output logic [`LANES-1:0] lane_valid,
  input  logic [`LANES-1:0] lane_ready,
  output lane_in_t          lane_data [`LANES]
);

  pixels_in_t        beat;
  logic [`LANES-1:0] pending;

  // lanes still owed the held beat, a new one waits until all have it
  assign s_ready    = (pending == '0);
  assign lane_valid = pending;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else if (s_valid && s_ready) begin
      pending <= '1;
    end else begin
      pending <= pending & ~lane_ready;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      beat <= s_data;
    end
  end

  // every lane sees the same shift and user word with its own column
  always_comb begin
    for (int i = 0; i < `LANES; i++) begin
      lane_data[i].data  = beat.data[i];
      lane_data[i].shift = beat.shift;
      lane_data[i].user  = beat.user;
    end
  end

  // a lane is offered a beat again only once a new input beat has been accepted
  assert property (@(posedge aclk) disable iff (!arst_n)
    ((lane_valid & ~$past(lane_valid)) != '0) |-> $past(s_valid && s_ready));

endmodule

// ==== verilog/axis_pixels_shift.sv ====
`timescale 1ns/1ps
`include "pixels_consts.svh"

module axis_pixels_shift import pixels_pkg::*; (
  input  logic      aclk,
  input  logic      arst_n,
  input  logic      s_valid,
  output logic      s_ready,
  input  lane_in_t  s_data,
  output logic      m_valid,
  input  logic      m_ready,
  output lane_out_t m_data
);

  logic                                       clken;
  logic                                       count_last;
  logic                                       count_en;
  logic [`BITS_SH-1:0]                        count;
  logic [`IM_SHIFT_REGS-1:0][`WORD_WIDTH-1:0] shift_regs;
  logic                                       reg_valid;
  logic [`TUSER_WIDTH_PIXELS-1:0]             reg_user;
  lane_out_t                                  window;

  // clken is the skid buffer taking the current window
  assign count_last = (count == '0);
  assign count_en   = clken && (count_last ? s_valid : 1'b1);
  assign s_ready    = clken && count_last;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      count     <= '0;
      reg_valid <= 1'b0;
    end else begin
      if (count_en) begin
        count <= count_last ? s_data.shift : count - 1'b1;
      end
      // valid stays up through the countdown and drops once input runs dry
      if (s_ready) begin
        reg_valid <= s_valid;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (count_en) begin
      if (count_last) begin
        shift_regs <= s_data.data;
        reg_user   <= s_data.user;
      end else begin
        shift_regs <= shift_regs >> `WORD_WIDTH;
      end
    end
  end

  // the bottom words form the window, zeros move in from the top
  assign window.data = shift_regs[`ROWS-1:0];
  assign window.user = reg_user;
  assign window.last = count_last;

  skid_buffer #(
    .WIDTH ($bits(lane_out_t))
  ) out_skid (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (reg_valid),
    .s_ready (clken),
    .s_data  (window),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  // a countdown always has its window waiting at the skid buffer input
  assert property (@(posedge aclk) disable iff (!arst_n)
    (count != '0) |-> reg_valid);

endmodule

// ==== verilog/pixels_gather.sv ====
`timescale 1ns/1ps
`include "pixels_consts.svh"

module pixels_gather import pixels_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  input  logic [`LANES-1:0] s_valid,
  output logic              s_ready,
  input  lane_out_t         s_data [`LANES],
  output logic              m_valid,
  input  logic              m_ready,
  output pixels_out_t       m_data
);

  logic              all_valid;
  logic              join_ready;
  logic [`LANES-1:0] last_bits;
  pixels_out_t       joined;

  // lanes only move together, so a slow lane holds back the others
  assign all_valid = &s_valid;
  assign s_ready   = all_valid && join_ready;

  always_comb begin
    joined.user = s_data[0].user;
    joined.last = s_data[0].last;
    for (int i = 0; i < `LANES; i++) begin
      joined.data[i] = s_data[i].data;
      last_bits[i]   = s_data[i].last;
    end
  end

  skid_buffer #(
    .WIDTH ($bits(pixels_out_t))
  ) out_skid (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (all_valid),
    .s_ready (join_ready),
    .s_data  (joined),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  // lanes count down in step, so they finish a window set on the same beat
  assert property (@(posedge aclk) disable iff (!arst_n)
    all_valid |-> ((last_bits == '0) || (last_bits == '1)));

endmodule

// ==== verilog/pixels_top.sv ====
`timescale 1ns/1ps
`include "pixels_consts.svh"

module pixels_top import pixels_pkg::*; (
  input  logic        aclk,
  input  logic        arst_n,
  input  logic        s_valid,
  output logic        s_ready,
  input  pixels_in_t  s_data,
  output logic        m_valid,
  input  logic        m_ready,
  output pixels_out_t m_data
);

  logic [`LANES-1:0] lane_in_valid;
  logic [`LANES-1:0] lane_in_ready;
  lane_in_t          lane_in_data [`LANES];
  logic [`LANES-1:0] lane_out_valid;
  logic              lane_out_ready;
  lane_out_t         lane_out_data [`LANES];

  pixels_dispatch dispatch_i (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .lane_valid (lane_in_valid),
    .lane_ready (lane_in_ready),
    .lane_data  (lane_in_data)
  );

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    axis_pixels_shift lane_i (
      .aclk    (aclk),
      .arst_n  (arst_n),
      .s_valid (lane_in_valid[i]),
      .s_ready (lane_in_ready[i]),
      .s_data  (lane_in_data[i]),
      .m_valid (lane_out_valid[i]),
      .m_ready (lane_out_ready),
      .m_data  (lane_out_data[i])
    );
  end

  // one ready releases every lane on the same edge
  pixels_gather gather_i (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (lane_out_valid),
    .s_ready (lane_out_ready),
    .s_data  (lane_out_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

endmodule

// ==== tests/pixels_tb.sv ====
`timescale 1ns/1ps
`include "pixels_consts.svh"

module pixels_tb import pixels_pkg::*; ;

  localparam int NUM_VECTORS = 36;
  localparam int VEC_BYTES   = `LANES * `IM_SHIFT_REGS + 3;
  localparam int CLK_PERIOD  = 20;
  localparam int TIMEOUT_NS  = NUM_VECTORS * (`KH_MAX + 1) * 20 * CLK_PERIOD;

  logic        aclk;
  logic        arst_n;
  logic        s_valid;
  logic        s_ready;
  pixels_in_t  s_data;
  logic        m_valid;
  logic        m_ready;
  pixels_out_t m_data;

  logic [7:0]  vec_mem [NUM_VECTORS*VEC_BYTES];
  pixels_in_t  vec_in [NUM_VECTORS];
  logic        vec_stall [NUM_VECTORS];
  int          vec_gap [NUM_VECTORS];
  int          vec_errors [NUM_VECTORS];
  int          vec_beats [NUM_VECTORS];

  pixels_out_t exp_q [$];
  int          exp_vec_q [$];

  integer      seed;
  int          errors;
  int          checked;
  int          total_beats;

  pixels_top pixels_top_i (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD/2) aclk = ~aclk;
  end

  // window j of a lane holds words j..j+ROWS-1, zeros past the last word
  function automatic pixels_out_t window_beat(input pixels_in_t in, input int j);
    pixels_out_t beat;
    int          idx;
    beat = '0;
    for (int l = 0; l < `LANES; l++) begin
      for (int r = 0; r < `ROWS; r++) begin
        idx = j + r;
        if (idx < `IM_SHIFT_REGS) begin
          beat.data[l][r] = in.data[l][idx];
        end
      end
    end
    beat.user = in.user;
    beat.last = (j == int'(in.shift));
    return beat;
  endfunction

  task automatic load_vectors();
    int base;
    $readmemh("tests/pixels_vectors.txt", vec_mem);
    for (int v = 0; v < NUM_VECTORS; v++) begin
      base = v * VEC_BYTES;
      for (int l = 0; l < `LANES; l++) begin
        for (int w = 0; w < `IM_SHIFT_REGS; w++) begin
          vec_in[v].data[l][w] = vec_mem[base + l*`IM_SHIFT_REGS + w];
        end
      end
      base = base + `LANES * `IM_SHIFT_REGS;
      vec_in[v].shift = vec_mem[base][`BITS_SH-1:0];
      vec_in[v].user  = vec_mem[base + 1][`TUSER_WIDTH_PIXELS-1:0];
      vec_stall[v]    = vec_mem[base + 2][0];
      vec_errors[v]   = 0;
      vec_beats[v]    = 0;
      // gaps are drawn up front so the stall draws alone use the seed later
      vec_gap[v]      = vec_stall[v] ? ($random(seed) & 3) : 0;
      for (int j = 0; j <= int'(vec_in[v].shift); j++) begin
        exp_q.push_back(window_beat(vec_in[v], j));
        exp_vec_q.push_back(v);
      end
    end
    total_beats = exp_q.size();
  endtask

  task automatic send_vector(input int v);
    repeat (vec_gap[v]) @(negedge aclk);
    s_data  = vec_in[v];
    s_valid = 1'b1;
    while (!s_ready) @(negedge aclk);
    @(negedge aclk);
    s_valid = 1'b0;
  endtask

  task automatic check_beat();
    pixels_out_t exp;
    int          v;
    assert (exp_q.size() != 0) else begin
      $display("an output beat arrived after every expected beat had been seen");
      errors++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      v   = exp_vec_q.pop_front();
      checked++;
      vec_beats[v]++;
      assert (m_data.data === exp.data) else begin
        $display("Error: m_data.data expected %h got %h", exp.data, m_data.data);
        errors++;
        vec_errors[v]++;
      end
      assert (m_data.user === exp.user) else begin
        $display("Error: m_data.user expected %h got %h", exp.user, m_data.user);
        errors++;
        vec_errors[v]++;
      end
      assert (m_data.last === exp.last) else begin
        $display("Error: m_data.last expected %h got %h", exp.last, m_data.last);
        errors++;
        vec_errors[v]++;
      end
      if (exp.last) begin
        $display("vector %0d shift %0d user %h: %0d beats, %s", v, vec_in[v].shift,
                 vec_in[v].user, vec_beats[v], (vec_errors[v] == 0) ? "ok" : "mismatch");
      end
    end
  endtask

  // m_ready is set and the output sampled here, both stable until the next rising edge
  initial begin
    m_ready = 1'b0;
    @(posedge arst_n);
    forever begin
      @(negedge aclk);
      if (exp_vec_q.size() != 0 && vec_stall[exp_vec_q[0]]) begin
        m_ready = ($random(seed) & 3) != 0;
      end else begin
        m_ready = 1'b1;
      end
      if (m_valid && m_ready) begin
        check_beat();
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: output beats stopped arriving with %0d of %0d still outstanding",
             exp_q.size(), total_beats);
    $display("sim failed");
    $finish;
  end

  initial begin
    arst_n  = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    seed    = 53;
    errors  = 0;
    checked = 0;
    load_vectors();
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    @(negedge aclk);
    assert (!m_valid) else begin
      $display("Error: m_valid after reset expected %h got %h", 1'b0, m_valid);
      errors++;
    end
    assert (s_ready) else begin
      $display("Error: s_ready after reset expected %h got %h", 1'b1, s_ready);
      errors++;
    end
    for (int v = 0; v < NUM_VECTORS; v++) begin
      send_vector(v);
    end
    while (exp_q.size() != 0) @(negedge aclk);
    // a few idle cycles let any duplicated beat show up
    repeat (6) @(negedge aclk);
    $display("%0d vectors, %0d of %0d beats checked, %0d errors",
             NUM_VECTORS, checked, total_beats, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/pixels_pkg.sv
verilog/skid_buffer.sv
verilog/pixels_dispatch.sv
verilog/axis_pixels_shift.sv
verilog/pixels_gather.sv
verilog/pixels_top.sv
tests/pixels_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the pixel shift stage with Verilator and runs its testbench

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot change to the project directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module pixels_tb -Mdir obj_dir -o pixels_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/pixels_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "$output" | grep -qx "sim passed"
if [ $? -ne 0 ]; then
  exit 1
fi
exit 0

// ==== tests/pixels_vectors.txt ====
// one input beat per line, all fields in hex
// lane 0 words 0..6, lane 1 words 0..6, lane 2 words 0..6, shift, user, stall flag
// a stall flag of 01 adds random valid gaps and m_ready stalls for that beat
00 01 02 03 04 05 06  10 11 12 13 14 15 16  20 21 22 23 24 25 26  00 01 00
a0 a1 a2 a3 a4 a5 a6  b0 b1 b2 b3 b4 b5 b6  c0 c1 c2 c3 c4 c5 c6  01 02 00
3f 7e bd fc 3b 7a b9  f8 37 76 b5 f4 33 72  b1 f0 2f 6e ad ec 2b  02 0a 00
11 22 33 44 55 66 77  88 99 aa bb cc dd ee  ff 0f 1e 2d 3c 4b 5a  03 0f 00
ff fe fd fc fb fa f9  80 7f 01 fe 02 fd 03  5a a5 5a a5 5a a5 5a  03 05 00
01 02 04 08 10 20 40  80 40 20 10 08 04 02  55 aa 55 aa 55 aa 55  00 0c 00
9c 4e 27 93 c9 e4 72  39 9c ce 67 b3 d9 6c  36 1b 8d c6 63 b1 58  02 06 00
6b d6 ad 5b b6 6d da  b5 6b d7 ae 5d ba 75  eb d7 af 5f be 7d fa  01 09 00
12 34 56 78 9a bc de  f0 e1 d2 c3 b4 a5 96  87 78 69 5a 4b 3c 2d  03 01 01
0e 1d 2c 3b 4a 59 68  77 86 95 a4 b3 c2 d1  e0 ef fe 0d 1c 2b 3a  00 04 01
49 58 67 76 85 94 a3  b2 c1 d0 df ee fd 0c  1b 2a 39 48 57 66 75  02 0e 01
84 93 a2 b1 c0 cf de  ed fc 0b 1a 29 38 47  56 65 74 83 92 a1 b0  01 07 01
bf ce dd ec fb 0a 19  28 37 46 55 64 73 82  91 a0 af be cd dc eb  03 0b 01
fa 09 18 27 36 45 54  63 72 81 90 9f ae bd  cc db ea f9 08 17 26  00 00 01
35 44 53 62 71 80 8f  9e ad bc cb da e9 f8  07 16 25 34 43 52 61  02 03 01
70 7f 8e 9d ac bb ca  d9 e8 f7 06 15 24 33  42 51 60 6f 7e 8d 9c  01 0d 01
ab ba c9 d8 e7 f6 05  14 23 32 41 50 5f 6e  7d 8c 9b aa b9 c8 d7  03 08 00
e6 f5 04 13 22 31 40  4f 5e 6d 7c 8b 9a a9  b8 c7 d6 e5 f4 03 12  00 02 00
21 30 3f 4e 5d 6c 7b  8a 99 a8 b7 c6 d5 e4  f3 02 11 20 2f 3e 4d  00 05 01
5c 6b 7a 89 98 a7 b6  c5 d4 e3 f2 01 10 1f  2e 3d 4c 5b 6a 79 88  00 0a 01
97 a6 b5 c4 d3 e2 f1  00 0f 1e 2d 3c 4b 5a  69 78 87 96 a5 b4 c3  03 0f 01
d2 e1 f0 ff 0e 1d 2c  3b 4a 59 68 77 86 95  a4 b3 c2 d1 e0 ef fe  03 06 01
0d 1c 2b 3a 49 58 67  76 85 94 a3 b2 c1 d0  df ee fd 0c 1b 2a 39  02 01 00
48 57 66 75 84 93 a2  b1 c0 cf de ed fc 0b  1a 29 38 47 56 65 74  01 0c 00
83 92 a1 b0 bf ce dd  ec fb 0a 19 28 37 46  55 64 73 82 91 a0 af  02 04 01
be cd dc eb fa 09 18  27 36 45 54 63 72 81  90 9f ae bd cc db ea  01 0e 01
f9 08 17 26 35 44 53  62 71 80 8f 9e ad bc  cb da e9 f8 07 16 25  00 07 01
34 43 52 61 70 7f 8e  9d ac bb ca d9 e8 f7  06 15 24 33 42 51 60  03 0b 01
6f 7e 8d 9c ab ba c9  d8 e7 f6 05 14 23 32  41 50 5f 6e 7d 8c 9b  02 09 01
aa b9 c8 d7 e6 f5 04  13 22 31 40 4f 5e 6d  7c 8b 9a a9 b8 c7 d6  01 03 01
e5 f4 03 12 21 30 3f  4e 5d 6c 7b 8a 99 a8  b7 c6 d5 e4 f3 02 11  03 0d 01
20 2f 3e 4d 5c 6b 7a  89 98 a7 b6 c5 d4 e3  f2 01 10 1f 2e 3d 4c  00 08 01
5b 6a 79 88 97 a6 b5  c4 d3 e2 f1 00 0f 1e  2d 3c 4b 5a 69 78 87  02 02 01
96 a5 b4 c3 d2 e1 f0  ff 0e 1d 2c 3b 4a 59  68 77 86 95 a4 b3 c2  01 0f 01
d1 e0 ef fe 0d 1c 2b  3a 49 58 67 76 85 94  a3 b2 c1 d0 df ee fd  03 00 01
0c 1b 2a 39 48 57 66  75 84 93 a2 b1 c0 cf  de ed fc 0b 1a 29 38  00 06 01
